// ==== verilog/nav_units_pkg.sv ====
// sign-magnitude fixed point: 1 sign bit, 8 integer cm bits, 8 fraction bits
// thresholds and speeds are build-time constants, not registers
package nav_units_pkg;

	//============================================================
	// number format
	//============================================================
	localparam int fix_width = 17;	// every distance, error and velocity
	localparam int sign_bit  = 16;	// msb carries the sign

	typedef logic [fix_width-1:0] fix_t;

	//============================================================
	// thresholds
	//============================================================
	// tolerance is compared on magnitude only
	localparam fix_t tol_err   = 17'b0_00001010_00000000;	// 10 cm
	// distances compare on the full unsigned value
	localparam fix_t safe_dist = 17'b0_00001111_00000000;	// 15 cm

	//============================================================
	// velocity commands
	//============================================================
	localparam fix_t vel_pos  = 17'b0_00110010_00000000;	// +50 cm/s
	localparam fix_t vel_neg  = 17'b1_00110010_00000000;	// -50 cm/s
	localparam fix_t vel_zero = 17'b0_00000000_00000000;

endpackage

// ==== verilog/nav_behavior_pkg.sv ====
// state codes are contiguous from zero, so a range test checks legality
// branch 3 and 4 states split into a side-pass half (a) and a watch half (b)
package nav_behavior_pkg;

	localparam int num_states = 27;	// members of nav_state_e

	//============================================================
	// controller states
	//============================================================
	typedef enum logic [4:0]
	{
		st_reset    = 5'd0,
		st_start    = 5'd1,
		st_goal     = 5'd2,	// go-to-goal behavior
		st_check_1  = 5'd3,	// front branch test
		st_check_2  = 5'd4,	// rear branch test
		st_check_3  = 5'd5,	// side-right branch test
		st_check_4  = 5'd6,	// side-left branch test
		st_move_1   = 5'd7,
		st_wait_1   = 5'd8,
		st_clear_1  = 5'd9,
		st_move_2   = 5'd10,
		st_wait_2   = 5'd11,
		st_clear_2  = 5'd12,
		st_side_3   = 5'd13,	// forward past the side obstacle
		st_wait_3a  = 5'd14,
		st_clear_3a = 5'd15,
		st_watch_3  = 5'd16,	// sideways until rear sees it
		st_pass_3   = 5'd17,
		st_wait_3b  = 5'd18,
		st_clear_3b = 5'd19,
		st_side_4   = 5'd20,
		st_wait_4a  = 5'd21,
		st_clear_4a = 5'd22,
		st_watch_4  = 5'd23,
		st_pass_4   = 5'd24,
		st_wait_4b  = 5'd25,
		st_clear_4b = 5'd26
	} nav_state_e;

	//============================================================
	// avoidance maneuvers
	//============================================================
	typedef enum logic [1:0]
	{
		mv_none    = 2'd0,	// robot follows the goal
		mv_right   = 2'd1,
		mv_left    = 2'd2,
		mv_forward = 2'd3
	} maneuver_e;

endpackage

// ==== verilog/obstacle_sensing.sv ====
// no state; every flag follows its inputs in the same cycle
// a distance with the sign bit set is treated as far away
`timescale 1ns/1ps

module obstacle_sensing
(
	input  nav_units_pkg::fix_t dist_1,	// front
	input  nav_units_pkg::fix_t dist_2,	// rear
	input  nav_units_pkg::fix_t dist_3,	// side right
	input  nav_units_pkg::fix_t dist_4,	// side left
	input  nav_units_pkg::fix_t err_x,
	input  nav_units_pkg::fix_t err_y,
	output logic                near_1,
	output logic                near_2,
	output logic                near_3,
	output logic                near_4,
	output logic                any_near,
	output logic                qual_1,
	output logic                qual_2,
	output logic                qual_3,
	output logic                qual_4
);

	logic [nav_units_pkg::sign_bit-1:0] mag_x;
	logic [nav_units_pkg::sign_bit-1:0] mag_y;
	logic                               neg_x;
	logic                               neg_y;
	logic                               far_x;
	logic                               far_y;

	//============================================================
	// obstacle detection
	//============================================================
	assign near_1 = (dist_1 <= nav_units_pkg::safe_dist);
	assign near_2 = (dist_2 <= nav_units_pkg::safe_dist);
	assign near_3 = (dist_3 <= nav_units_pkg::safe_dist);
	assign near_4 = (dist_4 <= nav_units_pkg::safe_dist);

	assign any_near = near_1 | near_2 | near_3 | near_4;

	//============================================================
	// position error against tolerance
	//============================================================
	assign mag_x   = err_x[nav_units_pkg::sign_bit-1:0];	// sign stripped
	assign mag_y   = err_y[nav_units_pkg::sign_bit-1:0];
	assign neg_x   = err_x[nav_units_pkg::sign_bit];
	assign neg_y   = err_y[nav_units_pkg::sign_bit];

	assign far_x = (mag_x > nav_units_pkg::tol_err[nav_units_pkg::sign_bit-1:0]);
	assign far_y = (mag_y > nav_units_pkg::tol_err[nav_units_pkg::sign_bit-1:0]);

	// escape branches tested in order by the sequencer
	assign qual_1 = near_1 & ~neg_y & far_y;	// goal ahead in y
	assign qual_2 = near_2 & neg_y & far_y;	// goal behind in y
	assign qual_3 = near_3 & ~neg_x & far_x & ~far_y;	// y already on target
	assign qual_4 = near_4 & neg_x & far_x & ~far_y;

endmodule

// ==== verilog/avoid_fsm.sv ====
// one state register, async active-high reset; the timer lives outside
// and is only seen through time_flag_n (low once the wait has elapsed)
`timescale 1ns/1ps

module avoid_fsm
(
	input  logic                   SC_STATEMACHINE_DESC_CLOCK_50,
	input  logic                   SC_STATEMACHINE_DESC_RESET_InHigh,
	input  logic                   near_1,
	input  logic                   near_2,
	input  logic                   near_3,
	input  logic                   near_4,
	input  logic                   any_near,
	input  logic                   qual_1,
	input  logic                   qual_2,
	input  logic                   qual_3,
	input  logic                   qual_4,
	input  logic                   time_flag_n,
	output nav_behavior_pkg::nav_state_e state
);

	nav_behavior_pkg::nav_state_e state_next;

	//============================================================
	// next-state logic
	//============================================================
	always_comb
	begin
		state_next = state;	// hold unless a rule below fires
		case (state)
			nav_behavior_pkg::st_reset:
				state_next = nav_behavior_pkg::st_start;
			nav_behavior_pkg::st_start:
				state_next = nav_behavior_pkg::st_goal;
			nav_behavior_pkg::st_goal:
				if (any_near)
					state_next = nav_behavior_pkg::st_check_1;

			// branch tests, one per cycle, first match wins
			nav_behavior_pkg::st_check_1:
				state_next = qual_1 ? nav_behavior_pkg::st_move_1 : nav_behavior_pkg::st_check_2;
			nav_behavior_pkg::st_check_2:
				state_next = qual_2 ? nav_behavior_pkg::st_move_2 : nav_behavior_pkg::st_check_3;
			nav_behavior_pkg::st_check_3:
				state_next = qual_3 ? nav_behavior_pkg::st_side_3 : nav_behavior_pkg::st_check_4;
			nav_behavior_pkg::st_check_4:
				state_next = qual_4 ? nav_behavior_pkg::st_side_4 : nav_behavior_pkg::st_goal;

			// branch 1, front obstacle
			nav_behavior_pkg::st_move_1:
				if (!near_1)
					state_next = nav_behavior_pkg::st_wait_1;
			nav_behavior_pkg::st_wait_1:
				if (!time_flag_n)
					state_next = nav_behavior_pkg::st_clear_1;
			nav_behavior_pkg::st_clear_1:
				state_next = nav_behavior_pkg::st_goal;

			// branch 2, rear obstacle
			nav_behavior_pkg::st_move_2:
				if (!near_2)
					state_next = nav_behavior_pkg::st_wait_2;
			nav_behavior_pkg::st_wait_2:
				if (!time_flag_n)
					state_next = nav_behavior_pkg::st_clear_2;
			nav_behavior_pkg::st_clear_2:
				state_next = nav_behavior_pkg::st_goal;

			// branch 3, obstacle on the right
			nav_behavior_pkg::st_side_3:
				if (!near_3)
					state_next = nav_behavior_pkg::st_wait_3a;
			nav_behavior_pkg::st_wait_3a:
				if (!time_flag_n)
					state_next = nav_behavior_pkg::st_clear_3a;
			nav_behavior_pkg::st_clear_3a:
				state_next = nav_behavior_pkg::st_watch_3;
			nav_behavior_pkg::st_watch_3:
				if (near_2)
					state_next = nav_behavior_pkg::st_pass_3;	// rear picked it up
			nav_behavior_pkg::st_pass_3:
				if (!near_2)
					state_next = nav_behavior_pkg::st_wait_3b;
			nav_behavior_pkg::st_wait_3b:
				if (!time_flag_n)
					state_next = nav_behavior_pkg::st_clear_3b;
			nav_behavior_pkg::st_clear_3b:
				state_next = nav_behavior_pkg::st_goal;

			// branch 4, obstacle on the left
			nav_behavior_pkg::st_side_4:
				if (!near_4)
					state_next = nav_behavior_pkg::st_wait_4a;
			nav_behavior_pkg::st_wait_4a:
				if (!time_flag_n)
					state_next = nav_behavior_pkg::st_clear_4a;
			nav_behavior_pkg::st_clear_4a:
				state_next = nav_behavior_pkg::st_watch_4;
			nav_behavior_pkg::st_watch_4:
				if (near_2)
					state_next = nav_behavior_pkg::st_pass_4;
			nav_behavior_pkg::st_pass_4:
				if (!near_2)
					state_next = nav_behavior_pkg::st_wait_4b;
			nav_behavior_pkg::st_wait_4b:
				if (!time_flag_n)
					state_next = nav_behavior_pkg::st_clear_4b;
			nav_behavior_pkg::st_clear_4b:
				state_next = nav_behavior_pkg::st_goal;

			default:
				state_next = nav_behavior_pkg::st_reset;	// unknown code recovers
		endcase
	end

	//============================================================
	// state register
	//============================================================
	always_ff @(posedge SC_STATEMACHINE_DESC_CLOCK_50 or posedge SC_STATEMACHINE_DESC_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_DESC_RESET_InHigh)
			state <= nav_behavior_pkg::st_reset;
		else
			state <= state_next;
	end

	// the register never leaves the encoded range once out of reset
	a_state_legal: assert property (@(posedge SC_STATEMACHINE_DESC_CLOCK_50)
		disable iff (SC_STATEMACHINE_DESC_RESET_InHigh)
		!$isunknown(state) && (int'(state) < nav_behavior_pkg::num_states));

endmodule

// ==== verilog/motion_command.sv ====
// Moore decode of the sequencer state; no clock, no reset
// right is negative y, left is positive y, forward is positive x
`timescale 1ns/1ps

module motion_command
(
	input  nav_behavior_pkg::nav_state_e state,
	output nav_units_pkg::fix_t          vel_x,
	output nav_units_pkg::fix_t          vel_y,
	output logic                         behavior,	// 1 go-to-goal, 0 avoid
	output logic                         enable_time_n,
	output logic                         clear_time_n
);

	nav_behavior_pkg::maneuver_e mv;

	//============================================================
	// state to maneuver
	//============================================================
	always_comb
	begin
		case (state)
			nav_behavior_pkg::st_move_1, nav_behavior_pkg::st_wait_1,
			nav_behavior_pkg::st_clear_1, nav_behavior_pkg::st_move_2,
			nav_behavior_pkg::st_wait_2, nav_behavior_pkg::st_clear_2,
			nav_behavior_pkg::st_watch_3, nav_behavior_pkg::st_pass_3,
			nav_behavior_pkg::st_wait_3b, nav_behavior_pkg::st_clear_3b:
				mv = nav_behavior_pkg::mv_right;
			nav_behavior_pkg::st_side_3, nav_behavior_pkg::st_wait_3a,
			nav_behavior_pkg::st_clear_3a, nav_behavior_pkg::st_side_4,
			nav_behavior_pkg::st_wait_4a, nav_behavior_pkg::st_clear_4a:
				mv = nav_behavior_pkg::mv_forward;	// slide past the side obstacle
			nav_behavior_pkg::st_watch_4, nav_behavior_pkg::st_pass_4,
			nav_behavior_pkg::st_wait_4b, nav_behavior_pkg::st_clear_4b:
				mv = nav_behavior_pkg::mv_left;
			default:
				mv = nav_behavior_pkg::mv_none;	// reset, start, goal, checks
		endcase
	end

	//============================================================
	// outputs
	//============================================================
	always_comb
	begin
		vel_x = nav_units_pkg::vel_zero;
		vel_y = nav_units_pkg::vel_zero;
		case (mv)
			nav_behavior_pkg::mv_right:   vel_y = nav_units_pkg::vel_neg;
			nav_behavior_pkg::mv_left:    vel_y = nav_units_pkg::vel_pos;
			nav_behavior_pkg::mv_forward: vel_x = nav_units_pkg::vel_pos;
			default:                      vel_x = nav_units_pkg::vel_zero;
		endcase
		behavior = (mv == nav_behavior_pkg::mv_none);

		// timer strobes, active low
		enable_time_n = !(state inside {nav_behavior_pkg::st_wait_1, nav_behavior_pkg::st_wait_2,
			nav_behavior_pkg::st_wait_3a, nav_behavior_pkg::st_wait_3b,
			nav_behavior_pkg::st_wait_4a, nav_behavior_pkg::st_wait_4b});
		clear_time_n = !(state inside {nav_behavior_pkg::st_clear_1, nav_behavior_pkg::st_clear_2,
			nav_behavior_pkg::st_clear_3a, nav_behavior_pkg::st_clear_3b,
			nav_behavior_pkg::st_clear_4a, nav_behavior_pkg::st_clear_4b});

		// the timer must never see count and clear at once
		a_strobe_excl: assert (enable_time_n || clear_time_n);
		// one axis at a time
		a_one_axis: assert ((vel_x == nav_units_pkg::vel_zero) || (vel_y == nav_units_pkg::vel_zero));
	end

endmodule

// ==== verilog/obstacle_avoid_top.sv ====
// behavior controller top; the wait timer is external, driven by the
// active-low strobes and read back through time_flag_n
`timescale 1ns/1ps

module obstacle_avoid_top
(
	input  logic                SC_STATEMACHINE_DESC_CLOCK_50,
	input  logic                SC_STATEMACHINE_DESC_RESET_InHigh,
	input  nav_units_pkg::fix_t dist_1,	// front
	input  nav_units_pkg::fix_t dist_2,	// rear
	input  nav_units_pkg::fix_t dist_3,	// side right
	input  nav_units_pkg::fix_t dist_4,	// side left
	input  nav_units_pkg::fix_t err_x,
	input  nav_units_pkg::fix_t err_y,
	input  logic                time_flag_n,
	output nav_units_pkg::fix_t vel_x,
	output nav_units_pkg::fix_t vel_y,
	output logic                behavior,
	output logic                enable_time_n,
	output logic                clear_time_n
);

	logic                         near_1;
	logic                         near_2;
	logic                         near_3;
	logic                         near_4;
	logic                         any_near;
	logic                         qual_1;
	logic                         qual_2;
	logic                         qual_3;
	logic                         qual_4;
	nav_behavior_pkg::nav_state_e state;

	obstacle_sensing u_sensing
	(
		.dist_1   (dist_1),
		.dist_2   (dist_2),
		.dist_3   (dist_3),
		.dist_4   (dist_4),
		.err_x    (err_x),
		.err_y    (err_y),
		.near_1   (near_1),
		.near_2   (near_2),
		.near_3   (near_3),
		.near_4   (near_4),
		.any_near (any_near),
		.qual_1   (qual_1),
		.qual_2   (qual_2),
		.qual_3   (qual_3),
		.qual_4   (qual_4)
	);

	avoid_fsm u_fsm
	(
		.SC_STATEMACHINE_DESC_CLOCK_50     (SC_STATEMACHINE_DESC_CLOCK_50),
		.SC_STATEMACHINE_DESC_RESET_InHigh (SC_STATEMACHINE_DESC_RESET_InHigh),
		.near_1      (near_1),
		.near_2      (near_2),
		.near_3      (near_3),
		.near_4      (near_4),
		.any_near    (any_near),
		.qual_1      (qual_1),
		.qual_2      (qual_2),
		.qual_3      (qual_3),
		.qual_4      (qual_4),
		.time_flag_n (time_flag_n),
		.state       (state)
	);

	motion_command u_cmd
	(
		.state         (state),
		.vel_x         (vel_x),
		.vel_y         (vel_y),
		.behavior      (behavior),
		.enable_time_n (enable_time_n),
		.clear_time_n  (clear_time_n)
	);

endmodule

// ==== verification/tb_obstacle_avoid.sv ====
// drives the controller top through directed branch runs and random stimulus
// the external wait timer is played by driving time_flag_n directly
// every output is compared against a reference model after each rising edge
`timescale 1ns/1ps

module tb_obstacle_avoid;

	localparam nav_units_pkg::fix_t far_d  = 17'h06400;	// 100 cm
	localparam nav_units_pkg::fix_t near_d = 17'h00500;	// 5 cm
	localparam nav_units_pkg::fix_t err_hi = 17'h01400;	// +20 cm
	localparam nav_units_pkg::fix_t err_lo = 17'h11400;	// -20 cm
	localparam nav_units_pkg::fix_t err_ok = 17'h00300;	// 3 cm inside tolerance
	localparam real watchdog_ns = (8 + 600 + 2000) * 40.0 * 1.1;

	logic                         SC_STATEMACHINE_DESC_CLOCK_50;
	logic                         SC_STATEMACHINE_DESC_RESET_InHigh;
	logic                         time_flag_n;
	logic                         behavior, enable_time_n, clear_time_n;
	nav_units_pkg::fix_t          dist_1, dist_2, dist_3, dist_4, err_x, err_y;
	nav_units_pkg::fix_t          vel_x, vel_y;
	nav_behavior_pkg::nav_state_e model_state;
	int                           errors;
	integer                       seed;

	obstacle_avoid_top u_dut (.*);

	initial SC_STATEMACHINE_DESC_CLOCK_50 = 1'b0;
	always #20 SC_STATEMACHINE_DESC_CLOCK_50 = ~SC_STATEMACHINE_DESC_CLOCK_50;

	//============================================================
	// reference model
	//============================================================
	function automatic logic sees(input nav_units_pkg::fix_t d);
		return d <= nav_units_pkg::safe_dist;	// sign set reads as far
	endfunction

	function automatic logic beyond(input nav_units_pkg::fix_t e);
		return (e & 17'h0ffff) > nav_units_pkg::tol_err;
	endfunction

	function automatic nav_behavior_pkg::nav_state_e ref_next(
		input nav_behavior_pkg::nav_state_e s,
		input nav_units_pkg::fix_t d1, d2, d3, d4, ex, ey,
		input logic tf_n);
		logic n2;
		logic q1, q2, q3, q4;
		n2 = sees(d2);
		q1 = sees(d1) && !ey[16] && beyond(ey);
		q2 = n2 && ey[16] && beyond(ey);
		q3 = sees(d3) && !ex[16] && beyond(ex) && !beyond(ey);
		q4 = sees(d4) && ex[16] && beyond(ex) && !beyond(ey);
		case (s)
			nav_behavior_pkg::st_reset:    return nav_behavior_pkg::st_start;
			nav_behavior_pkg::st_start:    return nav_behavior_pkg::st_goal;
			nav_behavior_pkg::st_goal:
				return (sees(d1) || n2 || sees(d3) || sees(d4)) ? nav_behavior_pkg::st_check_1 : s;
			nav_behavior_pkg::st_check_1:
				return q1 ? nav_behavior_pkg::st_move_1 : nav_behavior_pkg::st_check_2;
			nav_behavior_pkg::st_check_2:
				return q2 ? nav_behavior_pkg::st_move_2 : nav_behavior_pkg::st_check_3;
			nav_behavior_pkg::st_check_3:
				return q3 ? nav_behavior_pkg::st_side_3 : nav_behavior_pkg::st_check_4;
			nav_behavior_pkg::st_check_4:
				return q4 ? nav_behavior_pkg::st_side_4 : nav_behavior_pkg::st_goal;
			nav_behavior_pkg::st_move_1:   return sees(d1) ? s : nav_behavior_pkg::st_wait_1;
			nav_behavior_pkg::st_wait_1:   return tf_n ? s : nav_behavior_pkg::st_clear_1;
			nav_behavior_pkg::st_move_2:   return n2 ? s : nav_behavior_pkg::st_wait_2;
			nav_behavior_pkg::st_wait_2:   return tf_n ? s : nav_behavior_pkg::st_clear_2;
			nav_behavior_pkg::st_side_3:   return sees(d3) ? s : nav_behavior_pkg::st_wait_3a;
			nav_behavior_pkg::st_wait_3a:  return tf_n ? s : nav_behavior_pkg::st_clear_3a;
			nav_behavior_pkg::st_clear_3a: return nav_behavior_pkg::st_watch_3;
			nav_behavior_pkg::st_watch_3:  return n2 ? nav_behavior_pkg::st_pass_3 : s;
			nav_behavior_pkg::st_pass_3:   return n2 ? s : nav_behavior_pkg::st_wait_3b;
			nav_behavior_pkg::st_wait_3b:  return tf_n ? s : nav_behavior_pkg::st_clear_3b;
			nav_behavior_pkg::st_side_4:   return sees(d4) ? s : nav_behavior_pkg::st_wait_4a;
			nav_behavior_pkg::st_wait_4a:  return tf_n ? s : nav_behavior_pkg::st_clear_4a;
			nav_behavior_pkg::st_clear_4a: return nav_behavior_pkg::st_watch_4;
			nav_behavior_pkg::st_watch_4:  return n2 ? nav_behavior_pkg::st_pass_4 : s;
			nav_behavior_pkg::st_pass_4:   return n2 ? s : nav_behavior_pkg::st_wait_4b;
			nav_behavior_pkg::st_wait_4b:  return tf_n ? s : nav_behavior_pkg::st_clear_4b;
			default:                       return nav_behavior_pkg::st_goal;	// every clear
		endcase
	endfunction

	// state groups follow the package order of checks and branches
	function automatic void expect_outputs(input nav_behavior_pkg::nav_state_e s,
		output nav_units_pkg::fix_t vx, output nav_units_pkg::fix_t vy,
		output logic beh, output logic en_n, output logic clr_n);
		logic idle;
		logic fwd;
		logic left;
		idle = s inside {[nav_behavior_pkg::st_reset:nav_behavior_pkg::st_check_4]};
		fwd  = s inside {[nav_behavior_pkg::st_side_3:nav_behavior_pkg::st_clear_3a],
			[nav_behavior_pkg::st_side_4:nav_behavior_pkg::st_clear_4a]};
		left = s inside {[nav_behavior_pkg::st_watch_4:nav_behavior_pkg::st_clear_4b]};
		vx   = fwd ? nav_units_pkg::vel_pos : nav_units_pkg::vel_zero;
		vy   = (idle || fwd) ? nav_units_pkg::vel_zero :
			(left ? nav_units_pkg::vel_pos : nav_units_pkg::vel_neg);
		beh  = idle;
		en_n = !(s inside {nav_behavior_pkg::st_wait_1, nav_behavior_pkg::st_wait_2,
			nav_behavior_pkg::st_wait_3a, nav_behavior_pkg::st_wait_3b,
			nav_behavior_pkg::st_wait_4a, nav_behavior_pkg::st_wait_4b});
		clr_n = !(s inside {nav_behavior_pkg::st_clear_1, nav_behavior_pkg::st_clear_2,
			nav_behavior_pkg::st_clear_3a, nav_behavior_pkg::st_clear_3b,
			nav_behavior_pkg::st_clear_4a, nav_behavior_pkg::st_clear_4b});
	endfunction

	always @(posedge SC_STATEMACHINE_DESC_CLOCK_50 or posedge SC_STATEMACHINE_DESC_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_DESC_RESET_InHigh)
			model_state <= nav_behavior_pkg::st_reset;
		else
			model_state <= ref_next(model_state, dist_1, dist_2, dist_3, dist_4,
				err_x, err_y, time_flag_n);
	end

	//============================================================
	// compare
	//============================================================
	task automatic check_field(input string name, input logic [16:0] expected,
		input logic [16:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR: %0d ns %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	always @(posedge SC_STATEMACHINE_DESC_CLOCK_50)
	begin
		nav_units_pkg::fix_t vx, vy;
		logic beh, en_n, clr_n;
		#1;	// outputs settled after the edge
		if (!SC_STATEMACHINE_DESC_RESET_InHigh)
		begin
			expect_outputs(model_state, vx, vy, beh, en_n, clr_n);
			check_field("vel_x", vx, vel_x);
			check_field("vel_y", vy, vel_y);
			check_field("behavior", {16'd0, beh}, {16'd0, behavior});
			check_field("enable_time_n", {16'd0, en_n}, {16'd0, enable_time_n});
			check_field("clear_time_n", {16'd0, clr_n}, {16'd0, clear_time_n});
		end
	end

	//============================================================
	// stimulus helpers
	//============================================================
	task automatic wait_for_output(input string name, input logic level, input int limit);
		bit seen;
		int n;
		seen = 0;
		n = 0;
		while (!seen && n < limit)
		begin
			@(negedge SC_STATEMACHINE_DESC_CLOCK_50);
			n++;
			case (name)
				"behavior":      seen = (behavior === level);
				"enable_time_n": seen = (enable_time_n === level);
				default:         seen = (clear_time_n === level);
			endcase
		end
		if (!seen)
		begin
			errors++;
			$display("%s did not go to %b within %0d cycles (at %0d ns)", name, level, limit, $time);
		end
	endtask

	task automatic drive_idle();
		dist_1      = far_d;
		dist_2      = far_d;
		dist_3      = far_d;
		dist_4      = far_d;
		err_x       = 17'd0;
		err_y       = 17'd0;
		time_flag_n = 1'b1;
	endtask

	task automatic set_sensor(input int idx, input nav_units_pkg::fix_t d);
		case (idx)
			1:       dist_1 = d;
			2:       dist_2 = d;
			3:       dist_3 = d;
			default: dist_4 = d;
		endcase
	endtask

	// let the external wait run out once the controller starts the timer
	task automatic expire_timer();
		wait_for_output("enable_time_n", 1'b0, 4);
		repeat (2) @(negedge SC_STATEMACHINE_DESC_CLOCK_50);
		check_field("enable_time_n", 17'd0, {16'd0, enable_time_n});	// still waiting
		time_flag_n = 1'b0;
		wait_for_output("clear_time_n", 1'b0, 4);
		time_flag_n = 1'b1;
		@(negedge SC_STATEMACHINE_DESC_CLOCK_50);
		check_field("clear_time_n", 17'd1, {16'd0, clear_time_n});	// one cycle only
	endtask

	task automatic run_branch(input int b);
		drive_idle();
		err_x = (b == 3) ? err_hi : ((b == 4) ? err_lo : 17'd0);
		err_y = (b == 1) ? err_hi : ((b == 2) ? err_lo : err_ok);
		set_sensor(b, near_d);
		wait_for_output("behavior", 1'b0, 8);
		if (b <= 2)
			check_field("vel_y", nav_units_pkg::vel_neg, vel_y);	// moving right
		else
			check_field("vel_x", nav_units_pkg::vel_pos, vel_x);	// moving forward
		repeat (3) @(negedge SC_STATEMACHINE_DESC_CLOCK_50);
		set_sensor(b, far_d);
		expire_timer();
		if (b >= 3)
		begin
			check_field("vel_y", (b == 3) ? nav_units_pkg::vel_neg : nav_units_pkg::vel_pos, vel_y);
			repeat (2) @(negedge SC_STATEMACHINE_DESC_CLOCK_50);
			dist_2 = near_d;	// rear picks up the obstacle
			repeat (3) @(negedge SC_STATEMACHINE_DESC_CLOCK_50);
			dist_2 = far_d;
			expire_timer();
		end
		check_field("behavior", 17'd1, {16'd0, behavior});
	endtask

	// distances cluster around the safe distance with a few anywhere in range
	function automatic nav_units_pkg::fix_t random_dist();
		int r;
		r = $random(seed);
		case (r[2:0])
			3'd0:    return r[30:14];
			3'd1:    return nav_units_pkg::safe_dist;
			3'd2:    return nav_units_pkg::safe_dist + 17'd1;
			default: return nav_units_pkg::safe_dist - 17'h00300 + {6'd0, r[13:3]};
		endcase
	endfunction

	function automatic nav_units_pkg::fix_t random_err();
		int r;
		r = $random(seed);
		if (r[13:12] == 2'd0)
			return nav_units_pkg::tol_err | {r[20], 16'd0};	// right on the edge
		return (nav_units_pkg::tol_err - 17'h00400 + {6'd0, r[10:0]}) | {r[20], 16'd0};
	endfunction

	//============================================================
	// test sequence
	//============================================================
	initial
	begin
		seed = 32'h8a39f42a;
		errors = 0;
		SC_STATEMACHINE_DESC_RESET_InHigh = 1'b1;
		drive_idle();
		repeat (8) @(posedge SC_STATEMACHINE_DESC_CLOCK_50);
		@(negedge SC_STATEMACHINE_DESC_CLOCK_50);
		SC_STATEMACHINE_DESC_RESET_InHigh = 1'b0;
		repeat (6)
		begin
			@(negedge SC_STATEMACHINE_DESC_CLOCK_50);
			check_field("behavior", 17'd1, {16'd0, behavior});	// nothing in range
		end
		for (int b = 1; b <= 4; b++)
			run_branch(b);
		drive_idle();
		dist_1 = near_d;	// near but zero errors qualify no branch
		repeat (10)
		begin
			@(negedge SC_STATEMACHINE_DESC_CLOCK_50);
			check_field("behavior", 17'd1, {16'd0, behavior});
		end
		for (int i = 0; i < 2000; i++)
		begin
			@(negedge SC_STATEMACHINE_DESC_CLOCK_50);
			dist_1      = random_dist();
			dist_2      = random_dist();
			dist_3      = random_dist();
			dist_4      = random_dist();
			err_x       = random_err();
			err_y       = random_err();
			time_flag_n = ($random(seed) & 3) != 0;
		end
		@(negedge SC_STATEMACHINE_DESC_CLOCK_50);
		drive_idle();
		repeat (2) @(negedge SC_STATEMACHINE_DESC_CLOCK_50);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		#(watchdog_ns);
		$display("simulation timed out at %0d ns before the tests finished", $time);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== files.f ====
verilog/nav_units_pkg.sv
verilog/nav_behavior_pkg.sv
verilog/obstacle_sensing.sv
verilog/avoid_fsm.sv
verilog/motion_command.sv
verilog/obstacle_avoid_top.sv
verification/tb_obstacle_avoid.sv

// ==== Makefile ====
# Verilator build and run for the obstacle avoidance controller
# override any variable on the command line, e.g. make run TOP=tb_obstacle_avoid

TOP       ?= tb_obstacle_avoid
FILELIST  ?= files.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= TEST RESULT: PASS

SIM_EXE := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up in the simulator output
run: compile
	@out="$$(./$(SIM_EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
